/* verilog/floor_logic_pkg.sv */
package floor_logic_pkg;

    //////////////////////////////////////////////////////////////////////
    // Building geometry
    //////////////////////////////////////////////////////////////////////

    // Served floors with floor 0 at the bottom
    localparam int NUM_FLOORS = 11;

    // Floor index wide enough for all served floors
    typedef logic [3:0] floor_t;

    // One bit per served floor
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Car state machine interface
    //////////////////////////////////////////////////////////////////////

    // State code driven by the external car FSM
    typedef logic [5:0] car_state_t;

    // Codes 0 up to this one are the stop states with one per floor
    // Everything above is travel between floors or emergency
    localparam car_state_t STOP_LAST = 6'h0A;

    // Direction levels
    localparam logic DIR_UP   = 1'b1;
    localparam logic DIR_DOWN = 1'b0;

endpackage

/* verilog/car_stop_decode.sv */
`timescale 1ns/1ps

module car_stop_decode (
    input  logic                        clock,
    input  logic                        reset_n,
    input  floor_logic_pkg::car_state_t elevator_state,
    input  logic                        power_switch,
    input  logic                        door_open_btn,
    input  logic                        door_close_btn,
    output logic                        stopped,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed
);

    import floor_logic_pkg::*;

    // Car sits at a floor only in a stop state and with power on
    assign stopped = (elevator_state <= STOP_LAST) && power_switch;

    //////////////////////////////////////////////////////////////////////
    // Door permissions
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= stopped && door_open_btn;
            door_close_allowed <= stopped && door_close_btn;
        end
    end

    // Doors are never granted for a car that was moving
    a_no_door_while_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        !stopped |=> !door_open_allowed && !door_close_allowed
    ) else $error("door permission granted while car not stopped");

endmodule

/* verilog/request_registry.sv */
`timescale 1ns/1ps

module request_registry #(
    parameter int num_floors = floor_logic_pkg::NUM_FLOORS
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         power_switch,
    input  logic                         stopped,
    input  floor_logic_pkg::floor_t      current_floor,
    input  floor_logic_pkg::floor_mask_t floor_call_buttons,
    input  floor_logic_pkg::floor_mask_t panel_buttons,
    output floor_logic_pkg::floor_mask_t up_requests,
    output floor_logic_pkg::floor_mask_t down_requests,
    output floor_logic_pkg::floor_mask_t panel_requests,
    output floor_logic_pkg::floor_mask_t call_button_lights,
    output floor_logic_pkg::floor_mask_t panel_button_lights
);

    import floor_logic_pkg::*;

    floor_mask_t up_next;
    floor_mask_t down_next;
    floor_mask_t panel_next;
    floor_mask_t call_light_next;
    floor_mask_t panel_light_next;

    //////////////////////////////////////////////////////////////////////
    // Next request state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        up_next          = up_requests;
        down_next        = down_requests;
        panel_next       = panel_requests;
        call_light_next  = call_button_lights;
        panel_light_next = panel_button_lights;

        for (int f = 0; f < num_floors; f++) begin
            // Hall call direction depends on where the car is now
            if (floor_call_buttons[f]) begin
                if (f > current_floor) begin
                    up_next[f] = 1'b1;
                end else if (f < current_floor) begin
                    down_next[f] = 1'b1;
                end
                call_light_next[f] = 1'b1;
            end
            if (panel_buttons[f]) begin
                panel_next[f]       = 1'b1;
                panel_light_next[f] = 1'b1;
            end
        end

        // Arrival clear comes last so it overrides a press at this floor
        if (stopped && (current_floor < num_floors)) begin
            up_next[current_floor]          = 1'b0;
            down_next[current_floor]        = 1'b0;
            panel_next[current_floor]       = 1'b0;
            call_light_next[current_floor]  = 1'b0;
            panel_light_next[current_floor] = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            up_requests         <= '0;
            down_requests       <= '0;
            panel_requests      <= '0;
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (!power_switch) begin
            // Power loss drops every pending request
            up_requests         <= '0;
            down_requests       <= '0;
            panel_requests      <= '0;
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            up_requests         <= up_next;
            down_requests       <= down_next;
            panel_requests      <= panel_next;
            call_button_lights  <= call_light_next;
            panel_button_lights <= panel_light_next;
        end
    end

    a_power_off_clears: assert property (
        @(posedge clock) disable iff (!reset_n)
        !power_switch |=> (up_requests == '0) && (down_requests == '0)
            && (panel_requests == '0)
    ) else $error("requests survived power off");

    a_floor_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        current_floor < num_floors
    ) else $error("current_floor out of range");

endmodule

/* verilog/target_selector.sv */
`timescale 1ns/1ps

module target_selector #(
    parameter int num_floors = floor_logic_pkg::NUM_FLOORS
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         power_switch,
    input  logic                         emergency_btn,
    input  logic                         stopped,
    input  floor_logic_pkg::floor_t      current_floor,
    input  logic                         elevator_direction,
    input  floor_logic_pkg::floor_mask_t up_requests,
    input  floor_logic_pkg::floor_mask_t down_requests,
    input  floor_logic_pkg::floor_mask_t panel_requests,
    output floor_logic_pkg::floor_t      elevator_floor_selector,
    output logic                         direction_selector,
    output logic                         activate_elevator
);

    import floor_logic_pkg::*;

    floor_mask_t above;
    floor_mask_t below;
    floor_t      highest_above;
    floor_t      lowest_below;
    logic        go;

    //////////////////////////////////////////////////////////////////////
    // Candidate search
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        above         = '0;
        below         = '0;
        highest_above = current_floor;
        lowest_below  = current_floor;
        for (int f = 0; f < num_floors; f++) begin
            above[f] = (up_requests[f] || panel_requests[f]) && (f > current_floor);
            below[f] = (down_requests[f] || panel_requests[f]) && (f < current_floor);
        end
        // Ascending scan so the last hit is the highest floor
        for (int f = 0; f < num_floors; f++) begin
            if (above[f]) begin
                highest_above = floor_t'(f);
            end
        end
        // Descending scan so the last hit is the lowest floor
        for (int f = num_floors - 1; f >= 0; f--) begin
            if (below[f]) begin
                lowest_below = floor_t'(f);
            end
        end
    end

    assign go = power_switch && !emergency_btn && stopped && ((|above) || (|below));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            elevator_floor_selector <= '0;
            direction_selector      <= DIR_DOWN;
            activate_elevator       <= 1'b0;
        end else if (go) begin
            activate_elevator       <= 1'b1;
            elevator_floor_selector <= (|above) ? highest_above : lowest_below;
            // Boundary floors leave only one way to go
            if (current_floor == floor_t'(num_floors - 1)) begin
                direction_selector <= DIR_DOWN;
            end else if (current_floor == '0) begin
                direction_selector <= DIR_UP;
            end else begin
                direction_selector <= (|above) ? DIR_UP : DIR_DOWN;
            end
        end else begin
            activate_elevator       <= 1'b0;
            elevator_floor_selector <= current_floor;
            direction_selector      <= elevator_direction;
        end
    end

    // A dispatch always points the car away from where it stood
    a_target_moves_car: assert property (
        @(posedge clock) disable iff (!reset_n)
        activate_elevator |-> (elevator_floor_selector != $past(current_floor))
    ) else $error("activate_elevator with target equal to current floor");

endmodule

/* verilog/floor_logic_control_unit.sv */
`timescale 1ns/1ps

module floor_logic_control_unit #(
    parameter int num_floors = floor_logic_pkg::NUM_FLOORS
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  floor_logic_pkg::floor_mask_t floor_call_buttons,
    input  floor_logic_pkg::floor_mask_t panel_buttons,
    input  logic                         door_open_btn,
    input  logic                         door_close_btn,
    input  logic                         emergency_btn,
    input  logic                         power_switch,
    input  floor_logic_pkg::floor_t      current_floor,
    input  floor_logic_pkg::car_state_t  elevator_state,
    input  logic                         elevator_direction,
    output floor_logic_pkg::floor_t      elevator_floor_selector,
    output logic                         direction_selector,
    output logic                         activate_elevator,
    output floor_logic_pkg::floor_mask_t call_button_lights,
    output floor_logic_pkg::floor_mask_t panel_button_lights,
    output logic                         door_open_allowed,
    output logic                         door_close_allowed
);

    import floor_logic_pkg::*;

    logic        stopped;
    floor_mask_t up_requests;
    floor_mask_t down_requests;
    floor_mask_t panel_requests;

    //////////////////////////////////////////////////////////////////////
    // Stop detection and doors
    //////////////////////////////////////////////////////////////////////

    car_stop_decode u_stop (
        .clock              (clock),
        .reset_n            (reset_n),
        .elevator_state     (elevator_state),
        .power_switch       (power_switch),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .stopped            (stopped),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    //////////////////////////////////////////////////////////////////////
    // Pending requests and lights
    //////////////////////////////////////////////////////////////////////

    request_registry #(
        .num_floors (num_floors)
    ) u_requests (
        .clock               (clock),
        .reset_n             (reset_n),
        .power_switch        (power_switch),
        .stopped             (stopped),
        .current_floor       (current_floor),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .up_requests         (up_requests),
        .down_requests       (down_requests),
        .panel_requests      (panel_requests),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    // Next target for the car FSM
    target_selector #(
        .num_floors (num_floors)
    ) u_select (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .stopped                 (stopped),
        .current_floor           (current_floor),
        .elevator_direction      (elevator_direction),
        .up_requests             (up_requests),
        .down_requests           (down_requests),
        .panel_requests          (panel_requests),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator)
    );

endmodule

/* tests/tb_floor_logic.sv */
`timescale 1ns/1ps

module tb_floor_logic;

    import floor_logic_pkg::*;

    localparam time CLOCK_PERIOD = 40ns;
    localparam int  RESET_CYCLES = 2;
    localparam int  HOLD_CYCLES  = 3;
    localparam time DRIVE_DELAY  = 2ns;

    // One stimulus line with its expected outputs
    typedef struct packed {
        logic [7:0]  test_id;
        logic        power;
        logic        emergency;
        car_state_t  state;
        floor_t      floor;
        logic        direction;
        floor_mask_t call;
        floor_mask_t panel;
        logic        door_open;
        logic        door_close;
        logic        exp_activate;
        floor_t      exp_target;
        logic        exp_direction;
        floor_mask_t exp_call_lights;
        floor_mask_t exp_panel_lights;
        logic        exp_door_open;
        logic        exp_door_close;
    } vector_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    car_state_t  elevator_state;
    logic        elevator_direction;
    floor_t      elevator_floor_selector;
    logic        direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    vector_t vectors[$];
    int      errors;
    int      test_errors;
    int      test_vectors;
    int      tests_run;
    int      tests_failed;
    int      cycle_count;
    int      cycle_limit;

    floor_logic_control_unit #(
        .num_floors (NUM_FLOORS)
    ) u_dut (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_state          (elevator_state),
        .elevator_direction      (elevator_direction),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog limit is set once the vectors are loaded
    always @(posedge clock) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Vector file, stimulus and checks
    //////////////////////////////////////////////////////////////////////

    task automatic load_vectors;
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [17];
        vector_t     v;
        fd = $fopen("tests/floor_logic_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/floor_logic_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                // Comment and blank lines do not parse into 17 fields
                if (n == 17) begin
                    v = {f[0][7:0], f[1][0], f[2][0], f[3][5:0], f[4][3:0], f[5][0],
                         f[6][10:0], f[7][10:0], f[8][0], f[9][0], f[10][0], f[11][3:0],
                         f[12][0], f[13][10:0], f[14][10:0], f[15][0], f[16][0]};
                    vectors.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input vector_t v);
        power_switch       = v.power;
        emergency_btn      = v.emergency;
        elevator_state     = v.state;
        current_floor      = v.floor;
        elevator_direction = v.direction;
        floor_call_buttons = v.call;
        panel_buttons      = v.panel;
        door_open_btn      = v.door_open;
        door_close_btn     = v.door_close;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s expected %h actual %h", name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic check_outputs(input vector_t v);
        if (activate_elevator !== v.exp_activate)
            report_mismatch("activate_elevator", v.exp_activate, activate_elevator);
        if (elevator_floor_selector !== v.exp_target)
            report_mismatch("elevator_floor_selector", v.exp_target, elevator_floor_selector);
        if (direction_selector !== v.exp_direction)
            report_mismatch("direction_selector", v.exp_direction, direction_selector);
        if (call_button_lights !== v.exp_call_lights)
            report_mismatch("call_button_lights", v.exp_call_lights, call_button_lights);
        if (panel_button_lights !== v.exp_panel_lights)
            report_mismatch("panel_button_lights", v.exp_panel_lights, panel_button_lights);
        if (door_open_allowed !== v.exp_door_open)
            report_mismatch("door_open_allowed", v.exp_door_open, door_open_allowed);
        if (door_close_allowed !== v.exp_door_close)
            report_mismatch("door_close_allowed", v.exp_door_close, door_close_allowed);
    endtask

    initial begin
        reset_n            = 1'b0;
        power_switch       = 1'b0;
        emergency_btn      = 1'b0;
        elevator_state     = '0;
        current_floor      = '0;
        elevator_direction = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        errors             = 0;
        test_errors        = 0;
        test_vectors       = 0;
        tests_run          = 0;
        tests_failed       = 0;
        cycle_count        = 0;
        cycle_limit        = 0;

        load_vectors();
        if (vectors.size() == 0) begin
            $display("The vector file holds no usable lines");
            errors++;
        end
        cycle_limit = 3 * vectors.size() * HOLD_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY) reset_n = 1'b1;

        for (int i = 0; i < vectors.size(); i++) begin
            apply_vector(vectors[i]);
            repeat (HOLD_CYCLES) @(posedge clock);
            #1ns;
            check_outputs(vectors[i]);
            test_vectors++;
            // Last line of a test group closes the test
            if ((i == vectors.size() - 1) || (vectors[i + 1].test_id != vectors[i].test_id)) begin
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %0d: %0d vectors, %0d mismatches, %s", vectors[i].test_id,
                         test_vectors, test_errors, (test_errors == 0) ? "ok" : "bad");
                test_errors  = 0;
                test_vectors = 0;
            end
            #(DRIVE_DELAY - 1ns);
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tests/floor_logic_tests.txt */
# All fields hex: test power emergency state floor dir call panel door_open door_close
# then expected: activate target dir call_lights panel_lights door_open door_close

# Test 1: idle after reset, car stopped at floor 0
1 1 0 00 0 0 000 000 0 0   0 0 0 000 000 0 0

# Test 2: stopped at floor 3, requests above and below, highest above wins
2 1 0 03 3 0 042 100 0 0   1 8 1 042 100 0 0
2 1 0 03 3 0 000 000 0 0   1 8 1 042 100 0 0

# Test 3: only requests below, lowest wins, floor 0 is selectable
3 1 0 08 8 1 000 000 0 0   1 1 0 042 000 0 0
3 1 0 08 8 1 010 001 0 0   1 0 0 052 001 0 0

# Test 4: arrival clearing, presses at the current floor, boundary floors
4 1 0 00 0 0 000 000 0 0   1 6 1 052 000 0 0
4 1 0 04 4 0 010 010 0 0   1 6 1 042 000 0 0
4 1 0 0a a 1 400 200 0 0   1 1 0 042 200 0 0
4 1 0 06 6 0 000 000 0 0   1 9 1 002 200 0 0

# Test 5: emergency, travelling state and door permissions
5 1 1 06 6 1 000 000 1 0   0 6 1 002 200 1 0
5 1 0 10 7 1 008 000 1 1   0 7 1 00a 200 0 0
5 1 0 09 9 1 000 000 0 1   1 1 0 00a 000 0 1

# Test 6: power off clears everything and ignores presses
6 0 0 09 9 0 0f0 00f 1 0   0 9 0 000 000 0 0
6 1 0 09 9 0 000 000 0 0   0 9 0 000 000 0 0
6 1 0 09 9 0 000 004 0 0   1 2 0 000 004 0 0

/* filelist.f */
verilog/floor_logic_pkg.sv
verilog/car_stop_decode.sv
verilog/request_registry.sv
verilog/target_selector.sv
verilog/floor_logic_control_unit.sv
tests/tb_floor_logic.sv

/* Bender.yml */
package:
  name: floor_logic

sources:
  - verilog/floor_logic_pkg.sv
  - verilog/car_stop_decode.sv
  - verilog/request_registry.sv
  - verilog/target_selector.sv
  - verilog/floor_logic_control_unit.sv
  - target: simulation
    files:
      - tests/tb_floor_logic.sv
